// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_issue_stage
FILELIST  ?= issue_stage.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dispatch_regs.sv ====
module dispatch_regs (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                pipe_flush,
    input  logic                                issue_ip,
    input  logic                                issue_lsp,
    // Decoder fields and operands
    input  logic [issue_pkg::xlen-1:0]          dec_pc,
    input  issue_pkg::reg_idx_t                 dec_rd,
    input  logic                                dec_wb_en,
    input  issue_pkg::alu_op_t                  dec_op,
    input  logic [issue_pkg::xlen-1:0]          dec_imm,
    input  logic                                dec_mem_sign,
    input  logic [1:0]                          dec_mem_width,
    input  logic [issue_pkg::xlen-1:0]          operand1,
    input  logic [issue_pkg::xlen-1:0]          operand2,
    input  logic [issue_pkg::xlen-1:0]          br_base,
    // Integer pipe
    output logic                                ip_valid,
    input  logic                                ip_ready,
    output logic [issue_pkg::xlen-1:0]          ip_pc,
    output issue_pkg::reg_idx_t                 ip_dst,
    output logic                                ip_wb_en,
    output issue_pkg::alu_op_t                  ip_op,
    output logic [issue_pkg::xlen-1:0]          ip_operand1,
    output logic [issue_pkg::xlen-1:0]          ip_operand2,
    output logic [issue_pkg::xlen-1:0]          ip_br_base,
    output logic [issue_pkg::br_offset_w-1:0]   ip_br_offset,
    // Load/store pipe
    output logic                                lsp_valid,
    input  logic                                lsp_ready,
    output logic [issue_pkg::xlen-1:0]          lsp_pc,
    output issue_pkg::reg_idx_t                 lsp_dst,
    output logic                                lsp_wb_en,
    output logic [issue_pkg::xlen-1:0]          lsp_base,
    output logic [issue_pkg::lsp_offset_w-1:0]  lsp_offset,
    output logic [issue_pkg::xlen-1:0]          lsp_source,
    output logic                                lsp_mem_sign,
    output logic [1:0]                          lsp_mem_width
);
    import issue_pkg::*;

    // A new issue takes priority over draining the register
    always_ff @(posedge clk) begin
        if (rst) begin
            ip_valid  <= 1'b0;
            lsp_valid <= 1'b0;
        end else begin
            if (issue_ip)
                ip_valid <= 1'b1;
            else if (ip_ready || pipe_flush)
                ip_valid <= 1'b0;
            if (issue_lsp)
                lsp_valid <= 1'b1;
            else if (lsp_ready || pipe_flush)
                lsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_ip) begin
            ip_pc        <= dec_pc;
            ip_dst       <= dec_rd;
            ip_wb_en     <= dec_wb_en;
            ip_op        <= dec_op;
            ip_operand1  <= operand1;
            ip_operand2  <= operand2;
            ip_br_base   <= br_base;
            ip_br_offset <= dec_imm[br_offset_w-1:0];
        end
    end

    // Store data travels as operand2
    always_ff @(posedge clk) begin
        if (issue_lsp) begin
            lsp_pc        <= dec_pc;
            lsp_dst       <= dec_rd;
            lsp_wb_en     <= dec_wb_en;
            lsp_base      <= operand1;
            lsp_offset    <= dec_imm[lsp_offset_w-1:0];
            lsp_source    <= operand2;
            lsp_mem_sign  <= dec_mem_sign;
            lsp_mem_width <= dec_mem_width;
        end
    end

endmodule

// ==== issue_control.sv ====
module issue_control (
    input  logic                    rst,
    input  logic                    pipe_flush,
    // Decoder
    input  logic                    dec_valid,
    input  issue_pkg::op_type_t     dec_op_type,
    input  logic                    dec_wb_en,
    input  issue_pkg::reg_idx_t     dec_rd,
    output logic                    dec_ready,
    input  logic                    operands_ready,
    // Pipe state
    input  logic                    ip_ready,
    input  logic                    lsp_valid,
    input  logic                    lsp_ready,
    input  issue_pkg::reg_idx_t     lsp_dst,
    input  logic                    lsp_wb_en,
    input  logic                    lsp_mem_wb_en,
    input  issue_pkg::reg_idx_t     lsp_mem_dst,
    // Issue strobes
    output logic                    issue_ip,
    output logic                    issue_lsp
);
    import issue_pkg::*;

    logic waw_ok;
    logic is_ip_op;
    logic is_lsp_op;
    logic lsp_req_pending;
    logic issue_common;

    // Integer results retire earlier than older loads, so block a matching rd
    assign waw_ok = !dec_wb_en ||
                    ((!lsp_mem_wb_en || (lsp_mem_dst != dec_rd)) &&
                     (!lsp_valid || !lsp_wb_en || (lsp_dst != dec_rd)));

    assign is_ip_op  = (dec_op_type == ot_int) || (dec_op_type == ot_branch);
    assign is_lsp_op = (dec_op_type == ot_load) || (dec_op_type == ot_store);

    assign lsp_req_pending = lsp_valid && !lsp_ready;

    assign issue_common = dec_valid && operands_ready && !pipe_flush;

    // Branches wait for the load/store request ahead of them
    assign issue_ip = issue_common && ip_ready && waw_ok && is_ip_op &&
                      ((dec_op_type != ot_branch) || !lsp_req_pending);

    assign issue_lsp = issue_common && lsp_ready && is_lsp_op;

    assign dec_ready = !rst && !(dec_valid && !issue_ip && !issue_lsp && !pipe_flush);

endmodule

// ==== issue_pkg.sv ====
package issue_pkg;

    localparam int xlen = 64;
    localparam int lsp_offset_w = 12;
    localparam int br_offset_w = 21;

    // Index zero is the hardwired zero register
    typedef logic [4:0] reg_idx_t;

    typedef enum logic [1:0] {
        opr1_rs1  = 2'd0,
        opr1_pc   = 2'd1,
        opr1_zero = 2'd2,
        opr1_zimm = 2'd3
    } opr1_src_t;

    typedef enum logic [1:0] {
        opr2_rs2  = 2'd0,
        opr2_imm  = 2'd1,
        opr2_four = 2'd2
    } opr2_src_t;

    typedef enum logic {
        bb_pc  = 1'b0,
        bb_rs1 = 1'b1
    } br_base_src_t;

    // ot_other never issues and holds the decoder
    typedef enum logic [2:0] {
        ot_int    = 3'd0,
        ot_branch = 3'd1,
        ot_load   = 3'd2,
        ot_store  = 3'd3,
        ot_other  = 3'd4
    } op_type_t;

    // Low three bits follow funct3, bit 3 marks the alternate form
    typedef enum logic [3:0] {
        alu_add  = 4'b0000,
        alu_sll  = 4'b0001,
        alu_slt  = 4'b0010,
        alu_sltu = 4'b0011,
        alu_xor  = 4'b0100,
        alu_srl  = 4'b0101,
        alu_or   = 4'b0110,
        alu_and  = 4'b0111,
        alu_sub  = 4'b1000,
        alu_sra  = 4'b1101
    } alu_op_t;

endpackage

// ==== issue_stage.f ====
issue_pkg.sv
operand_bypass.sv
issue_control.sv
dispatch_regs.sv
issue_stage.sv
issue_stage_checker.sv
tb_issue_stage.sv

// ==== issue_stage.sv ====
module issue_stage (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                pipe_flush,
    // Register file
    output issue_pkg::reg_idx_t                 rf_rsrc0,
    input  logic [issue_pkg::xlen-1:0]          rf_rdata0,
    output issue_pkg::reg_idx_t                 rf_rsrc1,
    input  logic [issue_pkg::xlen-1:0]          rf_rdata1,
    // Decoder
    input  logic                                dec_valid,
    output logic                                dec_ready,
    input  logic [issue_pkg::xlen-1:0]          dec_pc,
    input  issue_pkg::alu_op_t                  dec_op,
    input  issue_pkg::op_type_t                 dec_op_type,
    input  issue_pkg::opr1_src_t                dec_operand1,
    input  issue_pkg::opr2_src_t                dec_operand2,
    input  issue_pkg::br_base_src_t             dec_br_base_src,
    input  logic [issue_pkg::xlen-1:0]          dec_imm,
    input  logic                                dec_mem_sign,
    input  logic [1:0]                          dec_mem_width,
    input  logic                                dec_wb_en,
    input  issue_pkg::reg_idx_t                 dec_rs1,
    input  issue_pkg::reg_idx_t                 dec_rs2,
    input  issue_pkg::reg_idx_t                 dec_rd,
    // Integer pipe
    output logic                                ip_valid,
    input  logic                                ip_ready,
    output logic [issue_pkg::xlen-1:0]          ip_pc,
    output issue_pkg::reg_idx_t                 ip_dst,
    output logic                                ip_wb_en,
    output issue_pkg::alu_op_t                  ip_op,
    output logic [issue_pkg::xlen-1:0]          ip_operand1,
    output logic [issue_pkg::xlen-1:0]          ip_operand2,
    output logic [issue_pkg::xlen-1:0]          ip_br_base,
    output logic [issue_pkg::br_offset_w-1:0]   ip_br_offset,
    input  logic [issue_pkg::xlen-1:0]          ip_fwd_value,
    input  logic                                ip_wb_valid,
    input  logic                                ip_wb_wb_en,
    input  issue_pkg::reg_idx_t                 ip_wb_dst,
    input  logic [issue_pkg::xlen-1:0]          ip_wb_result,
    // Load/store pipe
    output logic                                lsp_valid,
    input  logic                                lsp_ready,
    output logic [issue_pkg::xlen-1:0]          lsp_pc,
    output issue_pkg::reg_idx_t                 lsp_dst,
    output logic                                lsp_wb_en,
    output logic [issue_pkg::xlen-1:0]          lsp_base,
    output logic [issue_pkg::lsp_offset_w-1:0]  lsp_offset,
    output logic [issue_pkg::xlen-1:0]          lsp_source,
    output logic                                lsp_mem_sign,
    output logic [1:0]                          lsp_mem_width,
    input  logic                                lsp_mem_busy,
    input  logic                                lsp_mem_wb_en,
    input  issue_pkg::reg_idx_t                 lsp_mem_dst,
    input  logic                                lsp_wb_valid,
    input  logic                                lsp_wb_wb_en,
    input  issue_pkg::reg_idx_t                 lsp_wb_dst,
    input  logic [issue_pkg::xlen-1:0]          lsp_wb_result,
    // Write-back buffer
    input  logic                                wb_buf_valid,
    input  issue_pkg::reg_idx_t                 wb_buf_dst,
    input  logic [issue_pkg::xlen-1:0]          wb_buf_value
);
    import issue_pkg::*;

    logic [xlen-1:0] operand1;
    logic [xlen-1:0] operand2;
    logic [xlen-1:0] br_base;
    logic            operands_ready;
    logic            issue_ip;
    logic            issue_lsp;

    // All port names match the stage nets one to one
    operand_bypass u_operand_bypass (.*);

    issue_control u_issue_control (.*);

    dispatch_regs u_dispatch_regs (.*);

endmodule

// ==== issue_stage_checker.sv ====
module issue_stage_checker (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         pipe_flush,
    input  logic                         dec_ready,
    input  logic                         ip_valid,
    input  logic                         ip_ready,
    input  logic [issue_pkg::xlen-1:0]   ip_pc,
    input  logic [issue_pkg::xlen-1:0]   ip_operand1,
    input  logic [issue_pkg::xlen-1:0]   ip_operand2,
    input  logic                         lsp_valid,
    input  logic                         lsp_ready,
    input  logic [issue_pkg::xlen-1:0]   lsp_pc,
    input  logic [issue_pkg::xlen-1:0]   lsp_base,
    input  logic [issue_pkg::xlen-1:0]   lsp_source
);

    // Both output registers come out of reset empty
    assert property (@(posedge clk) rst |=> (!ip_valid && !lsp_valid))
        else $error("output valid in the cycle after reset");

    // Stalled payloads stay put
    assert property (@(posedge clk) disable iff (rst)
        (ip_valid && !ip_ready && !pipe_flush) |=>
            ($stable(ip_pc) && $stable(ip_operand1) && $stable(ip_operand2)))
        else $error("integer payload changed under back-pressure");

    assert property (@(posedge clk) disable iff (rst)
        (lsp_valid && !lsp_ready && !pipe_flush) |=>
            ($stable(lsp_pc) && $stable(lsp_base) && $stable(lsp_source)))
        else $error("load/store payload changed under back-pressure");

    assert property (@(posedge clk) rst |-> !dec_ready)
        else $error("dec_ready high during reset");

endmodule

bind issue_stage issue_stage_checker chk (.*);

// ==== operand_bypass.sv ====
module operand_bypass (
    // Register file read
    output issue_pkg::reg_idx_t          rf_rsrc0,
    input  logic [issue_pkg::xlen-1:0]   rf_rdata0,
    output issue_pkg::reg_idx_t          rf_rsrc1,
    input  logic [issue_pkg::xlen-1:0]   rf_rdata1,
    // Decoder fields
    input  issue_pkg::reg_idx_t          dec_rs1,
    input  issue_pkg::reg_idx_t          dec_rs2,
    input  logic [issue_pkg::xlen-1:0]   dec_pc,
    input  logic [issue_pkg::xlen-1:0]   dec_imm,
    input  issue_pkg::opr1_src_t         dec_operand1,
    input  issue_pkg::opr2_src_t         dec_operand2,
    input  issue_pkg::br_base_src_t      dec_br_base_src,
    // In-flight results
    input  logic [issue_pkg::xlen-1:0]   ip_fwd_value,
    input  logic                         ip_wb_valid,
    input  logic                         ip_wb_wb_en,
    input  issue_pkg::reg_idx_t          ip_wb_dst,
    input  logic [issue_pkg::xlen-1:0]   ip_wb_result,
    input  logic                         lsp_mem_busy,
    input  logic                         lsp_mem_wb_en,
    input  issue_pkg::reg_idx_t          lsp_mem_dst,
    input  logic                         lsp_wb_valid,
    input  logic                         lsp_wb_wb_en,
    input  issue_pkg::reg_idx_t          lsp_wb_dst,
    input  logic [issue_pkg::xlen-1:0]   lsp_wb_result,
    input  logic                         wb_buf_valid,
    input  issue_pkg::reg_idx_t          wb_buf_dst,
    input  logic [issue_pkg::xlen-1:0]   wb_buf_value,
    // Output registers of both pipes
    input  logic                         ip_valid,
    input  logic                         ip_ready,
    input  issue_pkg::reg_idx_t          ip_dst,
    input  logic                         ip_wb_en,
    input  logic                         lsp_valid,
    input  issue_pkg::reg_idx_t          lsp_dst,
    input  logic                         lsp_wb_en,
    // Selected operands
    output logic [issue_pkg::xlen-1:0]   operand1,
    output logic [issue_pkg::xlen-1:0]   operand2,
    output logic [issue_pkg::xlen-1:0]   br_base,
    output logic                         operands_ready
);
    import issue_pkg::*;

    logic ip_ex_fwd;
    logic ip_ex_stall;
    logic [xlen:0] rs1_res;
    logic [xlen:0] rs2_res;

    assign rf_rsrc0 = dec_rs1;
    assign rf_rsrc1 = dec_rs2;

    // Integer execute forwards once accepted, stalls while held
    assign ip_ex_fwd   = ip_valid && ip_ready && ip_wb_en;
    assign ip_ex_stall = ip_valid && !ip_ready && ip_wb_en;

    // Returns {ready, value}; later matches are younger and override earlier ones
    function automatic logic [xlen:0] resolve(input reg_idx_t src,
                                              input logic [xlen-1:0] rdata);
        logic rdy;
        logic [xlen-1:0] val;
        rdy = 1'b1;
        val = rdata;
        if (wb_buf_valid && (wb_buf_dst == src))
            val = wb_buf_value;
        if (ip_wb_valid && ip_wb_wb_en && (ip_wb_dst == src))
            val = ip_wb_result;
        if (ip_ex_fwd && (ip_dst == src))
            val = ip_fwd_value;
        if (ip_ex_stall && (ip_dst == src))
            rdy = 1'b0;
        if (lsp_wb_valid && lsp_wb_wb_en && (lsp_wb_dst == src)) begin
            rdy = 1'b1;
            val = lsp_wb_result;
        end
        // Loads in memory access have no data yet
        if (lsp_mem_busy && lsp_mem_wb_en && (lsp_mem_dst == src))
            rdy = 1'b0;
        if (lsp_valid && lsp_wb_en && (lsp_dst == src))
            rdy = 1'b0;
        // x0 wins even if some stage claims to write it
        if (src == '0) begin
            rdy = 1'b1;
            val = '0;
        end
        return {rdy, val};
    endfunction

    always_comb begin
        rs1_res = resolve(dec_rs1, rf_rdata0);
        rs2_res = resolve(dec_rs2, rf_rdata1);
    end

    always_comb begin
        case (dec_operand1)
            opr1_rs1:  operand1 = rs1_res[xlen-1:0];
            opr1_pc:   operand1 = dec_pc;
            opr1_zimm: operand1 = {{(xlen-5){1'b0}}, dec_rs1};
            default:   operand1 = '0;
        endcase
        case (dec_operand2)
            opr2_rs2:  operand2 = rs2_res[xlen-1:0];
            opr2_imm:  operand2 = dec_imm;
            opr2_four: operand2 = xlen'(4);
            default:   operand2 = '0;
        endcase
    end

    assign br_base = (dec_br_base_src == bb_pc) ? dec_pc : rs1_res[xlen-1:0];

    // An unused source never holds the instruction
    assign operands_ready = ((dec_operand1 != opr1_rs1) || rs1_res[xlen]) &&
                            ((dec_operand2 != opr2_rs2) || rs2_res[xlen]);

endmodule

// ==== tb_issue_stage.sv ====
module tb_issue_stage;
    import issue_pkg::*;

    // Expected operand sources
    localparam logic [3:0] s_rf = 4'd0;
    localparam logic [3:0] s_buf = 4'd1;
    localparam logic [3:0] s_ipwb = 4'd2;
    localparam logic [3:0] s_ipfwd = 4'd3;
    localparam logic [3:0] s_lspwb = 4'd4;
    localparam logic [3:0] s_zero = 4'd5;
    localparam logic [3:0] s_pc = 4'd6;
    localparam logic [3:0] s_zimm = 4'd7;
    localparam logic [3:0] s_imm = 4'd8;
    localparam logic [3:0] s_four = 4'd9;
    localparam int n_rows = 21;
    localparam int max_wait = 20;

    // Field pre first loads the integer register (1) or the load/store register (2) with pre_rd
    // Bits of hz enable write-back buffer (0), integer write-back (1), load/store write-back (2)
    // and mem load (3)
    typedef struct packed {
        op_type_t ot;
        alu_op_t op;
        opr1_src_t o1;
        opr2_src_t o2;
        br_base_src_t bb;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        logic wb;
        logic [1:0] pre;
        reg_idx_t pre_rd;
        logic [3:0] hz;
        reg_idx_t buf_dst;
        reg_idx_t ipwb_dst;
        reg_idx_t lspwb_dst;
        reg_idx_t mem_dst;
        logic ipr;
        logic lspr;
        logic flush;
        logic exp_rdy;
        logic exp_ip;
        logic exp_lsp;
        logic [3:0] e1;
        logic [3:0] e2;
        logic [3:0] eb;
    } row_t;

    logic clk;
    logic rst;
    logic pipe_flush;
    reg_idx_t rf_rsrc0;
    reg_idx_t rf_rsrc1;
    logic [xlen-1:0] rf_rdata0;
    logic [xlen-1:0] rf_rdata1;
    logic dec_valid;
    logic dec_ready;
    logic [xlen-1:0] dec_pc;
    alu_op_t dec_op;
    op_type_t dec_op_type;
    opr1_src_t dec_operand1;
    opr2_src_t dec_operand2;
    br_base_src_t dec_br_base_src;
    logic [xlen-1:0] dec_imm;
    logic dec_mem_sign;
    logic [1:0] dec_mem_width;
    logic dec_wb_en;
    reg_idx_t dec_rs1;
    reg_idx_t dec_rs2;
    reg_idx_t dec_rd;
    logic ip_valid;
    logic ip_ready;
    logic [xlen-1:0] ip_pc;
    reg_idx_t ip_dst;
    logic ip_wb_en;
    alu_op_t ip_op;
    logic [xlen-1:0] ip_operand1;
    logic [xlen-1:0] ip_operand2;
    logic [xlen-1:0] ip_br_base;
    logic [br_offset_w-1:0] ip_br_offset;
    logic [xlen-1:0] ip_fwd_value;
    logic ip_wb_valid;
    logic ip_wb_wb_en;
    reg_idx_t ip_wb_dst;
    logic [xlen-1:0] ip_wb_result;
    logic lsp_valid;
    logic lsp_ready;
    logic [xlen-1:0] lsp_pc;
    reg_idx_t lsp_dst;
    logic lsp_wb_en;
    logic [xlen-1:0] lsp_base;
    logic [lsp_offset_w-1:0] lsp_offset;
    logic [xlen-1:0] lsp_source;
    logic lsp_mem_sign;
    logic [1:0] lsp_mem_width;
    logic lsp_mem_busy;
    logic lsp_mem_wb_en;
    reg_idx_t lsp_mem_dst;
    logic lsp_wb_valid;
    logic lsp_wb_wb_en;
    reg_idx_t lsp_wb_dst;
    logic [xlen-1:0] lsp_wb_result;
    logic wb_buf_valid;
    reg_idx_t wb_buf_dst;
    logic [xlen-1:0] wb_buf_value;

    logic [xlen-1:0] rf_mem [32];
    row_t rows [n_rows];
    row_t r;
    int errors;
    int timeouts;
    logic exp_ipv;
    logic exp_lspv;

    issue_stage uut (.*);

    // Register file model
    assign rf_rdata0 = rf_mem[rf_rsrc0];
    assign rf_rdata1 = rf_mem[rf_rsrc1];

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    function automatic logic [63:0] expect_val(input logic [3:0] code, input reg_idx_t idx);
        logic [63:0] v;
        case (code)
            s_rf:    v = rf_mem[idx];
            s_buf:   v = wb_buf_value;
            s_ipwb:  v = ip_wb_result;
            s_ipfwd: v = ip_fwd_value;
            s_lspwb: v = lsp_wb_result;
            s_pc:    v = dec_pc;
            s_zimm:  v = {59'd0, dec_rs1};
            s_imm:   v = dec_imm;
            s_four:  v = 64'd4;
            default: v = 64'd0;
        endcase
        return v;
    endfunction

    task automatic quiet_hazards();
        pipe_flush = 1'b0;
        ip_wb_valid = 1'b0;
        ip_wb_wb_en = 1'b0;
        lsp_wb_valid = 1'b0;
        lsp_wb_wb_en = 1'b0;
        lsp_mem_busy = 1'b0;
        lsp_mem_wb_en = 1'b0;
        wb_buf_valid = 1'b0;
    endtask

    task automatic drain_pipes();
        int cnt;
        cnt = 0;
        dec_valid = 1'b0;
        ip_ready = 1'b1;
        lsp_ready = 1'b1;
        quiet_hazards();
        while ((ip_valid || lsp_valid) && cnt < max_wait) begin
            @(posedge clk);
            #10;
            cnt++;
        end
        if (ip_valid || lsp_valid) begin
            timeouts++;
            $display("Timeout: output registers did not drain at %0t", $time);
        end
    endtask

    // Puts one instruction into an output register so it can act as a hazard
    task automatic fill_register(input logic [1:0] kind, input reg_idx_t rd);
        int cnt;
        logic accepted;
        cnt = 0;
        accepted = 1'b0;
        dec_op_type = (kind == 2'd1) ? ot_int : ot_load;
        dec_op = alu_add;
        dec_operand1 = opr1_pc;
        dec_operand2 = opr2_imm;
        dec_rs1 = '0;
        dec_rs2 = '0;
        dec_rd = rd;
        dec_wb_en = 1'b1;
        dec_valid = 1'b1;
        while (!accepted && cnt < max_wait) begin
            #40;
            accepted = dec_ready;
            @(posedge clk);
            #10;
            cnt++;
        end
        dec_valid = 1'b0;
        if (!accepted) begin
            timeouts++;
            $display("Timeout: decoder was never accepted while filling a register");
        end
    endtask

    initial begin
        errors = 0;
        timeouts = 0;
        void'($urandom(32'hfe19_2519));
        for (int k = 0; k < 32; k++)
            rf_mem[k] = {$urandom, $urandom};

        // Integer write-back overrides the write-back buffer
        rows[0] = '{ot_int, alu_add, opr1_rs1, opr2_rs2, bb_pc, 5'd3, 5'd4, 5'd5, 1'b1, 2'd0,
                    5'd0, 4'b0011, 5'd4, 5'd4, 5'd0, 5'd0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0,
                    s_rf, s_ipwb, s_pc};
        rows[1] = '{ot_int, alu_sub, opr1_pc, opr2_imm, bb_rs1, 5'd6, 5'd1, 5'd2, 1'b1, 2'd0,
                    5'd0, 4'b0000, 5'd0, 5'd0, 5'd0, 5'd0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0,
                    s_pc, s_imm, s_rf};
        rows[2] = '{ot_int, alu_xor, opr1_zero, opr2_four, bb_pc, 5'd9, 5'd1, 5'd3, 1'b1, 2'd0,
                    5'd0, 4'b0000, 5'd0, 5'd0, 5'd0, 5'd0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0,
                    s_zero, s_four, s_pc};
        // x0 named by forwarding sources still reads zero
        rows[3] = '{ot_int, alu_or, opr1_zimm, opr2_rs2, bb_rs1, 5'd17, 5'd0, 5'd4, 1'b1, 2'd0,
                    5'd0, 4'b0011, 5'd0, 5'd0, 5'd0, 5'd0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0,
                    s_zimm, s_zero, s_rf};
        rows[4] = '{ot_branch, alu_sub, opr1_rs1, opr2_rs2, bb_rs1, 5'd8, 5'd8, 5'd0, 1'b0,
                    2'd0, 5'd0, 4'b0001, 5'd8, 5'd0, 5'd0, 5'd0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1,
                    1'b0, s_buf, s_buf, s_buf};
        rows[5] = '{ot_int, alu_and, opr1_rs1, opr2_rs2, bb_pc, 5'd10, 5'd11, 5'd6, 1'b1, 2'd1,
                    5'd10, 4'b0010, 5'd0, 5'd10, 5'd0, 5'd0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0,
                    s_ipfwd, s_rf, s_pc};
        rows[6] = '{ot_int, alu_sll, opr1_rs1, opr2_rs2, bb_pc, 5'd12, 5'd12, 5'd7, 1'b1, 2'd1,
                    5'd12, 4'b0111, 5'd12, 5'd12, 5'd12, 5'd0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1,
                    1'b0, s_lspwb, s_lspwb, s_pc};
        rows[7] = '{ot_int, alu_add, opr1_rs1, opr2_imm, bb_pc, 5'd13, 5'd1, 5'd8, 1'b1, 2'd0,
                    5'd0, 4'b1000, 5'd0, 5'd0, 5'd0, 5'd13, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0,
                    s_rf, s_imm, s_pc};
        rows[8] = '{ot_load, alu_add, opr1_pc, opr2_rs2, bb_pc, 5'd1, 5'd14, 5'd9, 1'b1, 2'd1,
                    5'd14, 4'b0000, 5'd0, 5'd0, 5'd0, 5'd0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0,
                    s_pc, s_rf, s_pc};
        rows[9] = '{ot_int, alu_add, opr1_rs1, opr2_imm, bb_pc, 5'd15, 5'd1, 5'd20, 1'b1, 2'd2,
                    5'd15, 4'b0000, 5'd0, 5'd0, 5'd0, 5'd0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0,
                    s_rf, s_imm, s_pc};
        rows[10] = '{ot_int, alu_slt, opr1_pc, opr2_imm, bb_pc, 5'd16, 5'd16, 5'd21, 1'b1,
                     2'd0, 5'd0, 4'b1000, 5'd0, 5'd0, 5'd0, 5'd16, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1,
                     1'b0, s_pc, s_imm, s_pc};
        rows[11] = '{ot_store, alu_add, opr1_rs1, opr2_rs2, bb_pc, 5'd2, 5'd3, 5'd0, 1'b0,
                     2'd1, 5'd18, 4'b0000, 5'd0, 5'd0, 5'd0, 5'd0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0,
                     1'b1, s_rf, s_rf, s_pc};
        rows[12] = '{ot_load, alu_add, opr1_rs1, opr2_imm, bb_pc, 5'd21, 5'd0, 5'd22, 1'b1,
                     2'd0, 5'd0, 4'b0000, 5'd0, 5'd0, 5'd0, 5'd0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0,
                     1'b1, s_rf, s_imm, s_pc};
        rows[13] = '{ot_int, alu_add, opr1_pc, opr2_imm, bb_pc, 5'd1, 5'd2, 5'd23, 1'b1, 2'd1,
                     5'd9, 4'b0000, 5'd0, 5'd0, 5'd0, 5'd0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0,
                     s_pc, s_imm, s_pc};
        rows[14] = '{ot_branch, alu_sub, opr1_pc, opr2_imm, bb_pc, 5'd0, 5'd0, 5'd0, 1'b0, 2'd2,
                     5'd24, 4'b0000, 5'd0, 5'd0, 5'd0, 5'd0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0,
                     s_pc, s_imm, s_pc};
        rows[15] = '{ot_branch, alu_sub, opr1_pc, opr2_imm, bb_pc, 5'd0, 5'd0, 5'd0, 1'b0, 2'd2,
                     5'd24, 4'b0000, 5'd0, 5'd0, 5'd0, 5'd0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0,
                     s_pc, s_imm, s_pc};
        rows[16] = '{ot_int, alu_srl, opr1_rs1, opr2_rs2, bb_pc, 5'd1, 5'd2, 5'd7, 1'b1, 2'd0,
                     5'd0, 4'b1000, 5'd0, 5'd0, 5'd0, 5'd7, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0,
                     s_rf, s_rf, s_pc};
        rows[17] = '{ot_int, alu_sra, opr1_rs1, opr2_rs2, bb_pc, 5'd1, 5'd2, 5'd8, 1'b1, 2'd0,
                     5'd0, 4'b1000, 5'd0, 5'd0, 5'd0, 5'd7, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0,
                     s_rf, s_rf, s_pc};
        rows[18] = '{ot_other, alu_add, opr1_pc, opr2_imm, bb_pc, 5'd0, 5'd0, 5'd0, 1'b0, 2'd0,
                     5'd0, 4'b0000, 5'd0, 5'd0, 5'd0, 5'd0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0,
                     s_pc, s_imm, s_pc};
        // A full pipe that is not ready holds back an instruction bound to it
        rows[19] = '{ot_int, alu_sltu, opr1_pc, opr2_imm, bb_pc, 5'd0, 5'd0, 5'd25, 1'b1, 2'd1,
                     5'd26, 4'b0000, 5'd0, 5'd0, 5'd0, 5'd0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0,
                     s_pc, s_imm, s_pc};
        rows[20] = '{ot_store, alu_add, opr1_pc, opr2_imm, bb_pc, 5'd0, 5'd0, 5'd0, 1'b0, 2'd2,
                     5'd27, 4'b0000, 5'd0, 5'd0, 5'd0, 5'd0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0,
                     s_pc, s_imm, s_pc};

        rst = 1'b1;
        dec_valid = 1'b0;
        dec_pc = '0;
        dec_op = alu_add;
        dec_op_type = ot_int;
        dec_operand1 = opr1_rs1;
        dec_operand2 = opr2_rs2;
        dec_br_base_src = bb_pc;
        dec_imm = '0;
        dec_mem_sign = 1'b0;
        dec_mem_width = 2'd0;
        dec_wb_en = 1'b0;
        dec_rs1 = '0;
        dec_rs2 = '0;
        dec_rd = '0;
        ip_ready = 1'b1;
        lsp_ready = 1'b1;
        ip_fwd_value = '0;
        ip_wb_dst = '0;
        ip_wb_result = '0;
        lsp_mem_dst = '0;
        lsp_wb_dst = '0;
        lsp_wb_result = '0;
        wb_buf_dst = '0;
        wb_buf_value = '0;
        quiet_hazards();
        repeat (3) @(posedge clk);
        #10;
        rst = 1'b0;

        for (int i = 0; i < n_rows; i++) begin
            r = rows[i];
            drain_pipes();
            if (r.pre != 2'd0)
                fill_register(r.pre, r.pre_rd);
            dec_op_type = r.ot;
            dec_op = r.op;
            dec_operand1 = r.o1;
            dec_operand2 = r.o2;
            dec_br_base_src = r.bb;
            dec_rs1 = r.rs1;
            dec_rs2 = r.rs2;
            dec_rd = r.rd;
            dec_wb_en = r.wb;
            dec_pc = {$urandom, $urandom};
            dec_imm = {$urandom, $urandom};
            dec_mem_sign = 1'($urandom);
            dec_mem_width = 2'($urandom);
            ip_fwd_value = {$urandom, $urandom};
            wb_buf_valid = r.hz[0];
            wb_buf_dst = r.buf_dst;
            wb_buf_value = {$urandom, $urandom};
            ip_wb_valid = r.hz[1];
            ip_wb_wb_en = r.hz[1];
            ip_wb_dst = r.ipwb_dst;
            ip_wb_result = {$urandom, $urandom};
            lsp_wb_valid = r.hz[2];
            lsp_wb_wb_en = r.hz[2];
            lsp_wb_dst = r.lspwb_dst;
            lsp_wb_result = {$urandom, $urandom};
            lsp_mem_busy = r.hz[3];
            lsp_mem_wb_en = r.hz[3];
            lsp_mem_dst = r.mem_dst;
            ip_ready = r.ipr;
            lsp_ready = r.lspr;
            pipe_flush = r.flush;
            dec_valid = 1'b1;
            #40;
            check($sformatf("row %0d dec_ready", i), 64'(dec_ready), 64'(r.exp_rdy));
            exp_ipv = r.exp_ip || ((r.pre == 2'd1) && !r.ipr && !r.flush);
            exp_lspv = r.exp_lsp || ((r.pre == 2'd2) && !r.lspr && !r.flush);
            @(posedge clk);
            #10;
            check($sformatf("row %0d ip_valid", i), 64'(ip_valid), 64'(exp_ipv));
            check($sformatf("row %0d lsp_valid", i), 64'(lsp_valid), 64'(exp_lspv));
            // A stalled register still carries the instruction that filled it
            if ((r.pre == 2'd1) && !r.ipr && !r.flush)
                check("held ip_dst", 64'(ip_dst), 64'(r.pre_rd));
            if ((r.pre == 2'd2) && !r.lspr && !r.flush)
                check("held lsp_dst", 64'(lsp_dst), 64'(r.pre_rd));
            if (r.exp_ip) begin
                check("ip_pc", ip_pc, dec_pc);
                check("ip_dst", 64'(ip_dst), 64'(r.rd));
                check("ip_wb_en", 64'(ip_wb_en), 64'(r.wb));
                check("ip_op", 64'(ip_op), 64'(r.op));
                check("ip_operand1", ip_operand1, expect_val(r.e1, r.rs1));
                check("ip_operand2", ip_operand2, expect_val(r.e2, r.rs2));
                check("ip_br_base", ip_br_base, expect_val(r.eb, r.rs1));
                check("ip_br_offset", 64'(ip_br_offset), 64'(dec_imm[20:0]));
            end
            if (r.exp_lsp) begin
                check("lsp_pc", lsp_pc, dec_pc);
                check("lsp_dst", 64'(lsp_dst), 64'(r.rd));
                check("lsp_wb_en", 64'(lsp_wb_en), 64'(r.wb));
                check("lsp_base", lsp_base, expect_val(r.e1, r.rs1));
                check("lsp_offset", 64'(lsp_offset), 64'(dec_imm[11:0]));
                check("lsp_source", lsp_source, expect_val(r.e2, r.rs2));
                check("lsp_mem_sign", 64'(lsp_mem_sign), 64'(dec_mem_sign));
                check("lsp_mem_width", 64'(lsp_mem_width), 64'(dec_mem_width));
            end
        end
        drain_pipes();

        $display("Finished: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
